// File: list.f
design/mem_pkg.sv
design/rom_slot.sv
design/rw_slot.sv
design/slot_arbiter.sv
design/mem_subsys.sv
testbench/mem_subsys_asserts.sv
testbench/tb_mem_subsys.sv

// File: testbench/tb_mem_subsys.sv
// directed testbench for mem_subsys with a Wishbone memory model; run tb_mem_subsys as top
`timescale 1ns/100ps
`default_nettype none

module tb_mem_subsys;

    logic                        clk = 1'b0;
    logic                        rst;
    logic                        rom0_cs, rom1_cs, ram_cs, ram_we;
    logic [mem_pkg::slot_aw-1:0] rom0_addr, rom1_addr, ram_addr;
    logic [15:0]                 ram_wdata;
    logic                        rom0_ok, rom1_ok, ram_ok;
    logic [7:0]                  rom0_dout;
    logic [15:0]                 rom1_dout, ram_dout;
    mem_pkg::wb_m2s_t            wb_o;
    mem_pkg::wb_s2m_t            wb_i = '0;

    integer                      seed = 32'hdd74;     // wait state source
    int                          waits;
    logic                        busy = 1'b0;          // model inside a bus cycle
    logic [mem_pkg::mem_aw-1:0]  bus_log [$];          // one address per bus cycle
    mem_pkg::mem_word_u          ram_mem [256];        // low part of the RAM region

    mem_subsys dut0 (.*);

    bind slot_arbiter mem_subsys_asserts arb_checks (
        .clk(clk), .rst(rst), .reqs(reqs), .rsps(rsps), .wb_o(wb_o), .wb_i(wb_i)
    );

    always #2 clk = ~clk;  // 4 ns period

    ////////////////////////////////////////////////////////////////////////////
    // memory model
    ////////////////////////////////////////////////////////////////////////////

    // rom content rule, also the RAM start value
    function automatic mem_pkg::mem_word_u rule_word(input logic [mem_pkg::mem_aw-1:0] a);
        mem_pkg::mem_word_u r;
        r.w = {a[15:0] ^ 16'h5a5a, a[15:0]};
        return r;
    endfunction

    function automatic mem_pkg::mem_word_u as_word(input logic [mem_pkg::mem_aw-1:0] a);
        mem_pkg::mem_word_u r;
        r.w = 32'(a);  // zero extended bus address
        return r;
    endfunction

    initial begin
        for (int i = 0; i < 256; i++) begin
            ram_mem[i] = rule_word(mem_pkg::ram_base + mem_pkg::mem_aw'(i));
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            wb_i <= '0;
            busy = 1'b0;
        end else if (wb_i.ack) begin
            wb_i <= '0;                                // ack lasts one cycle
        end else if (wb_o.cyc && wb_o.stb) begin
            if (!busy) begin
                busy = 1'b1;
                waits = $random(seed) & 3;             // 0 to 3 wait states
                bus_log.push_back(wb_o.adr);
            end
            if (waits == 0) begin
                busy = 1'b0;
                if (wb_o.adr >= mem_pkg::ram_base) begin
                    for (int k = 0; k < 4; k++) begin
                        if (wb_o.we && wb_o.sel[k]) begin
                            ram_mem[wb_o.adr[7:0]].b[k] = wb_o.dat[8*k +: 8];
                        end
                    end
                    wb_i <= '{ack: 1'b1, dat: ram_mem[wb_o.adr[7:0]]};
                end else begin
                    wb_i <= '{ack: 1'b1, dat: rule_word(wb_o.adr)};  // rom, writes dropped
                end
            end else begin
                waits = waits - 1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) stop_on_error($sformatf("ERROR %0t ns: %s expected %h got %h",
                                                 $time, name, exp, act));
    endtask

    task automatic check_half(input string name, input logic [15:0] exp, input logic [15:0] act);
        if (act !== exp) stop_on_error($sformatf("ERROR %0t ns: %s expected %h got %h",
                                                 $time, name, exp, act));
    endtask

    task automatic check_word(input string name, input mem_pkg::mem_word_u exp,
                              input mem_pkg::mem_word_u act);
        if (act.w !== exp.w) stop_on_error($sformatf("ERROR %0t ns: %s expected %h got %h",
                                                     $time, name, exp.w, act.w));
    endtask

    task automatic check_count(input string name, input integer exp, input integer act);
        if (act !== exp) stop_on_error($sformatf("ERROR %0t ns: %s expected %0d got %0d",
                                                 $time, name, exp, act));
    endtask

    // ok sampled on the falling edge, away from the DUT's updates
    task automatic wait_ok(input int slot, input string name);
        int   n;
        logic seen;
        seen = 1'b0;
        for (n = 0; n < 50 && !seen; n++) begin
            @(negedge clk);
            case (slot)
                mem_pkg::slot_rw:   seen = ram_ok;
                mem_pkg::slot_rom0: seen = rom0_ok;
                default:            seen = rom1_ok;
            endcase
        end
        if (!seen) stop_on_error({"the ", name, " slot never answered within 50 cycles"});
    endtask

    // a failed arbiter handshake assertion ends the run at once
    always @(negedge clk) begin
        if (dut0.arb.arb_checks.fail_count != 0) begin
            stop_on_error("an arbiter handshake assertion failed");
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // client drivers
    ////////////////////////////////////////////////////////////////////////////

    task automatic read_rom0(input logic [mem_pkg::slot_aw-1:0] a);
        mem_pkg::mem_word_u exp;
        exp = rule_word(mem_pkg::rom0_base + mem_pkg::mem_aw'(a >> 2));
        @(posedge clk);
        rom0_cs   <= 1'b1;
        rom0_addr <= a;
        wait_ok(mem_pkg::slot_rom0, "rom0");
        check_byte("rom0_dout", exp.b[a[1:0]], rom0_dout);
        @(posedge clk);
        rom0_cs <= 1'b0;
    endtask

    task automatic read_rom1(input logic [mem_pkg::slot_aw-1:0] a);
        mem_pkg::mem_word_u exp;
        exp = rule_word(mem_pkg::rom1_base + mem_pkg::mem_aw'(a >> 1));
        @(posedge clk);
        rom1_cs   <= 1'b1;
        rom1_addr <= a;
        wait_ok(mem_pkg::slot_rom1, "rom1");
        check_half("rom1_dout", exp.h[a[0]], rom1_dout);
        @(posedge clk);
        rom1_cs <= 1'b0;
    endtask

    task automatic ram_read(input logic [mem_pkg::slot_aw-1:0] a);
        logic [15:0] exp;
        exp = ram_mem[a[8:1]].h[a[0]];  // whatever the array holds now
        @(posedge clk);
        ram_cs   <= 1'b1;
        ram_we   <= 1'b0;
        ram_addr <= a;
        wait_ok(mem_pkg::slot_rw, "ram");
        check_half("ram_dout", exp, ram_dout);
        @(posedge clk);
        ram_cs <= 1'b0;
    endtask

    task automatic ram_write(input logic [mem_pkg::slot_aw-1:0] a, input logic [15:0] d);
        @(posedge clk);
        ram_cs    <= 1'b1;
        ram_we    <= 1'b1;
        ram_addr  <= a;
        ram_wdata <= d;
        wait_ok(mem_pkg::slot_rw, "ram");
        @(posedge clk);
        ram_cs <= 1'b0;
        ram_we <= 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic rom0_byte_reads();
        logic [mem_pkg::slot_aw-1:0] a;
        int n;
        for (int i = 0; i < 4; i++) begin
            a = mem_pkg::slot_aw'(i * 'h0b3c5 + 'h11);  // a new word each time
            n = bus_log.size();
            read_rom0(a);
            check_count("rom0 bus cycles", n + 1, bus_log.size());
            check_word("wb_o.adr", as_word(mem_pkg::rom0_base + mem_pkg::mem_aw'(a >> 2)),
                       as_word(bus_log[$]));
        end
    endtask

    task automatic rom1_half_reads();
        logic [mem_pkg::slot_aw-1:0] a;
        int n;
        for (int i = 0; i < 4; i++) begin
            a = mem_pkg::slot_aw'(i * 'h0c6a3 + 'h7);
            n = bus_log.size();
            read_rom1(a);
            check_count("rom1 bus cycles", n + 1, bus_log.size());
            check_word("wb_o.adr", as_word(mem_pkg::rom1_base + mem_pkg::mem_aw'(a >> 1)),
                       as_word(bus_log[$]));
        end
    endtask

    task automatic cache_hits_and_eviction();
        int n0;
        n0 = bus_log.size();
        for (int b = 0; b < 4; b++) read_rom0(18'h01000 + 18'(b));  // all lanes of one word
        check_count("bus cycles after one word", n0 + 1, bus_log.size());
        for (int i = 0; i < 4; i++) begin
            read_rom0(18'h02000 + 18'(i));
            read_rom0(18'h01003 - 18'(i));
        end
        check_count("bus cycles after two words", n0 + 2, bus_log.size());
        read_rom0(18'h03001);                           // evicts the first filled word
        check_count("bus cycles after third word", n0 + 3, bus_log.size());
        read_rom0(18'h02002);                           // still cached
        check_count("bus cycles on second word", n0 + 3, bus_log.size());
        read_rom0(18'h01000);
        check_count("bus cycles on evicted word", n0 + 4, bus_log.size());
    endtask

    task automatic ram_write_read();
        mem_pkg::mem_word_u exp;
        for (int k = 3; k < 20; k += 7) begin
            exp = rule_word(mem_pkg::ram_base + mem_pkg::mem_aw'(k));
            exp.h[1] = 16'hc3a0 ^ 16'(k);
            ram_write(18'(2 * k + 1), exp.h[1]);         // upper half only
            check_word("ram word", exp, ram_mem[k]);
            ram_read(18'(2 * k + 1));
            ram_read(18'(2 * k));
            exp.h[0] = 16'h1e5b + 16'(k);
            ram_write(18'(2 * k), exp.h[0]);
            check_word("ram word", exp, ram_mem[k]);
            ram_read(18'(2 * k));
            ram_read(18'(2 * k + 1));
        end
    endtask

    task automatic concurrent_requests();
        int n;
        n = bus_log.size();
        fork
            read_rom0(18'h04444);
            read_rom1(18'h05555);
            ram_read(18'h00042);
        join
        check_count("concurrent bus cycles", n + 3, bus_log.size());
        // priority order rw, rom0, rom1
        check_word("wb_o.adr", as_word(mem_pkg::ram_base + 22'h21), as_word(bus_log[n]));
        check_word("wb_o.adr", as_word(mem_pkg::rom0_base + 22'h1111), as_word(bus_log[n + 1]));
        check_word("wb_o.adr", as_word(mem_pkg::rom1_base + 22'h2aaa), as_word(bus_log[n + 2]));
    endtask

    // limit set well above the length of all directed tests
    initial begin
        repeat (4000) @(posedge clk);
        stop_on_error("timeout, the tests did not finish within 4000 clock cycles");
    end

    initial begin
        rst       = 1'b1;
        rom0_cs   = 1'b0;
        rom0_addr = '0;
        rom1_cs   = 1'b0;
        rom1_addr = '0;
        ram_cs    = 1'b0;
        ram_we    = 1'b0;
        ram_addr  = '0;
        ram_wdata = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        rom0_byte_reads();
        rom1_half_reads();
        cache_hits_and_eviction();
        ram_write_read();
        concurrent_requests();
        repeat (4) @(posedge clk);
        if (dut0.arb.arb_checks.fail_count != 0) begin
            stop_on_error($sformatf("%0d arbiter assertion failures",
                                    dut0.arb.arb_checks.fail_count));
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: testbench/mem_subsys_asserts.sv
// arbiter handshake checks, bound into every slot_arbiter instance by the testbench
`timescale 1ns/100ps
`default_nettype none

module mem_subsys_asserts (
    input  wire logic                                        clk,
    input  wire logic                                        rst,
    input  wire mem_pkg::slot_req_t [mem_pkg::num_slots-1:0] reqs,
    input  wire mem_pkg::slot_rsp_t [mem_pkg::num_slots-1:0] rsps,
    input  wire mem_pkg::wb_m2s_t                            wb_o,
    input  wire mem_pkg::wb_s2m_t                            wb_i
);

    int fail_count = 0;  // read by the testbench

    // classic cycles only, strobe tracks cycle
    stb_is_cyc: assert property (@(posedge clk) disable iff (rst) wb_o.stb == wb_o.cyc)
        else begin
            fail_count++;
            $error("wishbone stb differs from cyc");
        end

    // open cycle keeps its address until the slave answers
    cyc_held: assert property (@(posedge clk) disable iff (rst)
        (wb_o.cyc && !wb_i.ack) |=> (wb_o.cyc && $stable(wb_o.adr)))
        else begin
            fail_count++;
            $error("wishbone cycle dropped or address moved before ack");
        end

    one_ack: assert property (@(posedge clk) disable iff (rst)
        $onehot0({rsps[2].ack, rsps[1].ack, rsps[0].ack}))
        else begin
            fail_count++;
            $error("more than one slot acked in the same cycle");
        end

    // an ack never reaches a slot that is not asking
    for (genvar i = 0; i < mem_pkg::num_slots; i++) begin : g_ack_req
        ack_needs_req: assert property (@(posedge clk) disable iff (rst)
            rsps[i].ack |-> reqs[i].req)
            else begin
                fail_count++;
                $error("slot %0d acked without a request", i);
            end
    end

endmodule

`default_nettype wire

// File: design/mem_subsys.sv
// memory request top level, three client slots sharing one Wishbone master port
`timescale 1ns/100ps
`default_nettype none

module mem_subsys (
    input  wire logic                        clk,
    input  wire logic                        rst,

    // rom0 client, byte wide
    input  wire logic                        rom0_cs,
    input  wire logic [mem_pkg::slot_aw-1:0] rom0_addr,
    output logic                             rom0_ok,
    output logic [7:0]                       rom0_dout,

    // rom1 client, halfword wide
    input  wire logic                        rom1_cs,
    input  wire logic [mem_pkg::slot_aw-1:0] rom1_addr,
    output logic                             rom1_ok,
    output logic [15:0]                      rom1_dout,

    // ram client
    input  wire logic                        ram_cs,
    input  wire logic                        ram_we,
    input  wire logic [mem_pkg::slot_aw-1:0] ram_addr,
    input  wire logic [15:0]                 ram_wdata,
    output logic                             ram_ok,
    output logic [15:0]                      ram_dout,

    // memory side
    output mem_pkg::wb_m2s_t                 wb_o,
    input  wire mem_pkg::wb_s2m_t            wb_i
);

    wire mem_pkg::slot_req_t [mem_pkg::num_slots-1:0] reqs;  // indexed by slot number
    wire mem_pkg::slot_rsp_t [mem_pkg::num_slots-1:0] rsps;

    rom_slot #(.dw(8), .base(mem_pkg::rom0_base)) rom0_slot (
        .clk     (clk),
        .rst     (rst),
        .cs      (rom0_cs),
        .addr    (rom0_addr),
        .ok      (rom0_ok),
        .dout    (rom0_dout),
        .bus_req (reqs[mem_pkg::slot_rom0]),
        .bus_rsp (rsps[mem_pkg::slot_rom0])
    );

    rom_slot #(.dw(16), .base(mem_pkg::rom1_base)) rom1_slot (
        .clk     (clk),
        .rst     (rst),
        .cs      (rom1_cs),
        .addr    (rom1_addr),
        .ok      (rom1_ok),
        .dout    (rom1_dout),
        .bus_req (reqs[mem_pkg::slot_rom1]),
        .bus_rsp (rsps[mem_pkg::slot_rom1])
    );

    rw_slot #(.base(mem_pkg::ram_base)) ram_slot (
        .clk     (clk),
        .rst     (rst),
        .cs      (ram_cs),
        .we      (ram_we),
        .addr    (ram_addr),
        .wdata   (ram_wdata),
        .ok      (ram_ok),
        .dout    (ram_dout),
        .bus_req (reqs[mem_pkg::slot_rw]),
        .bus_rsp (rsps[mem_pkg::slot_rw])
    );

    slot_arbiter arb (
        .clk  (clk),
        .rst  (rst),
        .reqs (reqs),
        .rsps (rsps),
        .wb_o (wb_o),
        .wb_i (wb_i)
    );

endmodule

`default_nettype wire

// File: design/slot_arbiter.sv
// fixed-priority arbiter that runs the granted slot request as a Wishbone classic master cycle
`timescale 1ns/100ps
`default_nettype none

module slot_arbiter (
    input  wire logic                                                clk,
    input  wire logic                                                rst,
    input  wire mem_pkg::slot_req_t [mem_pkg::num_slots-1:0]         reqs,
    output mem_pkg::slot_rsp_t [mem_pkg::num_slots-1:0]              rsps,
    output mem_pkg::wb_m2s_t                                         wb_o,
    input  wire mem_pkg::wb_s2m_t                                    wb_i
);

    logic [mem_pkg::slot_iw-1:0]  pick;     // winner among current requests
    logic                         any_req;
    logic                         start;    // grant taken this cycle

    // control state
    logic                         cyc_q;    // bus cycle open, also the strobe
    logic [mem_pkg::slot_iw-1:0]  gnt_q;    // slot that owns the cycle

    // registered request payload
    logic                         we_q;
    logic [mem_pkg::mem_aw-1:0]   adr_q;
    logic [31:0]                  dat_q;
    logic [3:0]                   sel_q;

    ////////////////////////////////////////////////////////////////////////////
    // priority pick
    ////////////////////////////////////////////////////////////////////////////

    // scan from the lowest priority up so slot 0 overrides the rest
    always_comb begin
        pick    = '0;
        any_req = 1'b0;
        for (int i = mem_pkg::num_slots - 1; i >= 0; i--) begin
            if (reqs[i].req) begin
                pick    = mem_pkg::slot_iw'(i);
                any_req = 1'b1;
            end
        end
    end

    assign start = !cyc_q && any_req;  // only from idle

    ////////////////////////////////////////////////////////////////////////////
    // bus cycle
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cyc_q <= 1'b0;
            gnt_q <= '0;
        end else if (cyc_q) begin
            if (wb_i.ack) begin
                cyc_q <= 1'b0;  // close the cycle, back to idle
            end
        end else if (start) begin
            cyc_q <= 1'b1;
            gnt_q <= pick;      // held until the ack
        end
    end

    // payload copied once per grant, stable for the whole cycle
    always_ff @(posedge clk) begin
        if (start) begin
            we_q  <= reqs[pick].we;
            adr_q <= reqs[pick].adr;
            dat_q <= reqs[pick].dat;
            sel_q <= reqs[pick].sel;
        end
    end

    assign wb_o = '{
        cyc: cyc_q,
        stb: cyc_q,   // classic cycle, no idle strobes
        we:  we_q,
        adr: adr_q,
        dat: dat_q,
        sel: sel_q
    };

    ////////////////////////////////////////////////////////////////////////////
    // response routing
    ////////////////////////////////////////////////////////////////////////////

    // ack goes to the owner in the same cycle as the bus ack
    always_comb begin
        for (int i = 0; i < mem_pkg::num_slots; i++) begin
            rsps[i].ack = cyc_q && wb_i.ack && (gnt_q == mem_pkg::slot_iw'(i));
            rsps[i].dat = rsps[i].ack ? wb_i.dat : '0;  // others see nothing
        end
    end

endmodule

`default_nettype wire

// File: design/rw_slot.sv
// read/write halfword client slot, one uncached bus access per rising edge of its select
`timescale 1ns/100ps
`default_nettype none

module rw_slot #(
    parameter logic [mem_pkg::mem_aw-1:0]    base = '0  // region base, word address
) (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic                        cs,
    input  wire logic                        we,
    input  wire logic [mem_pkg::slot_aw-1:0] addr,   // halfword address
    input  wire logic [15:0]                 wdata,
    output logic                             ok,
    output logic [15:0]                      dout,
    output mem_pkg::slot_req_t               bus_req,
    input  wire mem_pkg::slot_rsp_t          bus_rsp
);

    logic                         cs_d;
    logic                         start;   // new access accepted

    logic                         req_q;
    logic                         we_q;
    logic                         half_q;  // addr bit 0, picks the halfword
    logic [mem_pkg::mem_aw-1:0]   adr_q;
    logic [31:0]                  dat_q;
    logic [3:0]                   sel_q;

    // edge of cs, ignored while a request is still out
    assign start = cs && !cs_d && !req_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cs_d  <= 1'b0;
            req_q <= 1'b0;
            ok    <= 1'b0;
        end else begin
            cs_d <= cs;
            ok   <= bus_rsp.ack;  // one cycle pulse
            if (bus_rsp.ack) begin
                req_q <= 1'b0;
            end else if (start) begin
                req_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            we_q   <= we;
            half_q <= addr[0];
            adr_q  <= base + mem_pkg::mem_aw'(addr >> 1);
            dat_q  <= {wdata, wdata};  // same halfword on both lanes
            // writes touch one halfword, reads take the word
            sel_q  <= we ? (addr[0] ? 4'b1100 : 4'b0011) : 4'b1111;
        end
        if (bus_rsp.ack && !we_q) begin
            dout <= bus_rsp.dat.h[half_q];  // writes leave dout alone
        end
    end

    assign bus_req = '{req: req_q, we: we_q, adr: adr_q, dat: dat_q, sel: sel_q};

endmodule

`default_nettype wire

// File: design/rom_slot.sv
// read-only client slot with a two word cache; instantiate once per ROM region with its lane width
`timescale 1ns/100ps
`default_nettype none

module rom_slot #(
    parameter int                            dw   = 8,   // 8, 16 or 32
    parameter logic [mem_pkg::mem_aw-1:0]    base = '0   // region base, word address
) (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic                        cs,
    input  wire logic [mem_pkg::slot_aw-1:0] addr,
    output logic                             ok,
    output logic [dw-1:0]                    dout,
    output mem_pkg::slot_req_t               bus_req,
    input  wire mem_pkg::slot_rsp_t          bus_rsp
);

    // address bits that pick the lane inside a word
    localparam int lsb = (dw == 8) ? 2 : (dw == 16) ? 1 : 0;

    logic [mem_pkg::mem_aw-1:0]   word_adr;   // client address as a bus word
    logic [1:0]                   hit_vec;
    logic                         hit;
    logic                         miss_start;

    logic                         req_q;      // bus request pending
    logic [mem_pkg::mem_aw-1:0]   adr_q;      // word being fetched

    // two cache entries
    logic [1:0]                         valid;
    logic [1:0][mem_pkg::mem_aw-1:0]    tag;
    mem_pkg::mem_word_u [1:0]           cdata;
    logic                               repl;  // entry to fill next, toggles per fill

    mem_pkg::mem_word_u           src;        // word the lane comes from
    logic [dw-1:0]                lane;

    ////////////////////////////////////////////////////////////////////////////
    // lookup
    ////////////////////////////////////////////////////////////////////////////

    assign word_adr = base + mem_pkg::mem_aw'(addr >> lsb);

    assign hit_vec[0] = valid[0] && (tag[0] == word_adr);
    assign hit_vec[1] = valid[1] && (tag[1] == word_adr);
    assign hit        = |hit_vec;

    // a miss only issues when nothing is in flight
    assign miss_start = cs && !hit && !req_q;

    // fresh bus data bypasses the cache on the fill cycle
    assign src = bus_rsp.ack ? bus_rsp.dat : (hit_vec[0] ? cdata[0] : cdata[1]);

    generate
        if (dw == 8) begin : g_byte
            assign lane = src.b[addr[1:0]];
        end else if (dw == 16) begin : g_half
            assign lane = src.h[addr[0]];
        end else begin : g_word
            assign lane = src.w;  // full word, no lane bits
        end
    endgenerate

    ////////////////////////////////////////////////////////////////////////////
    // control
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req_q <= 1'b0;
            ok    <= 1'b0;
            valid <= 2'b00;
            repl  <= 1'b0;
        end else begin
            ok <= bus_rsp.ack || (cs && hit);  // fill answer or cache hit
            if (bus_rsp.ack) begin
                req_q       <= 1'b0;          // low in the cycle after ack
                valid[repl] <= 1'b1;
                repl        <= ~repl;         // round robin over the two entries
            end else if (miss_start) begin
                req_q <= 1'b1;
            end
        end
    end

    // address latch, cache contents and read data
    always_ff @(posedge clk) begin
        if (miss_start) begin
            adr_q <= word_adr;
        end
        if (bus_rsp.ack) begin
            tag[repl]   <= adr_q;
            cdata[repl] <= bus_rsp.dat;
        end
        if (bus_rsp.ack || (cs && hit)) begin
            dout <= lane;
        end
    end

    // reads only, whole word
    assign bus_req = '{req: req_q, we: 1'b0, adr: adr_q, dat: 32'h0, sel: 4'hf};

endmodule

`default_nettype wire

// File: design/mem_pkg.sv
// address map, sizes and bus types shared by every memory subsystem block and its testbench
`default_nettype none

package mem_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // sizes
    ////////////////////////////////////////////////////////////////////////////

    localparam int mem_aw    = 22;                 // bus word address
    localparam int slot_aw   = 18;                 // client side address
    localparam int num_slots = 3;
    localparam int slot_iw   = $clog2(num_slots);  // grant index width

    // slot numbering, the lower index wins arbitration
    localparam int slot_rw   = 0;
    localparam int slot_rom0 = 1;
    localparam int slot_rom1 = 2;

    // region bases, all word addresses
    localparam logic [mem_aw-1:0] rom0_base = 22'h000000;
    localparam logic [mem_aw-1:0] rom1_base = 22'h100000;
    localparam logic [mem_aw-1:0] ram_base  = 22'h200000;

    ////////////////////////////////////////////////////////////////////////////
    // data word and bus types
    ////////////////////////////////////////////////////////////////////////////

    // one fetched word, read back by lanes of different widths
    typedef union packed {
        logic [3:0][7:0]  b;  // b[0] sits in bits 7..0
        logic [1:0][15:0] h;  // h[0] sits in bits 15..0
        logic [31:0]      w;
    } mem_word_u;

    // slot to arbiter request, held until ack
    typedef struct packed {
        logic              req;
        logic              we;
        logic [mem_aw-1:0] adr;  // word address
        logic [31:0]       dat;  // write data
        logic [3:0]        sel;  // byte enables
    } slot_req_t;

    // arbiter to slot answer, ack is a one cycle pulse
    typedef struct packed {
        logic      ack;
        mem_word_u dat;  // read data, valid with ack
    } slot_rsp_t;

    // wishbone classic master outputs
    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [mem_aw-1:0] adr;
        logic [31:0]       dat;
        logic [3:0]        sel;
    } wb_m2s_t;

    // wishbone slave answer
    typedef struct packed {
        logic      ack;
        mem_word_u dat;
    } wb_s2m_t;

endpackage

`default_nettype wire
